// File: rtl/capsense_defines.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register widths and reset values are fixed by the register map
// Control bits 7:6 are stored but have no function
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef CAPSENSE_DEFINES_SVH
`define CAPSENSE_DEFINES_SVH

// Register data, prescaler and PRS width
`define CS_DATA_W           8

// Scan-speed counter, one dpulse every 32 clocks
`define CS_SCAN_CNT_W       5
`define CS_SCAN_PERIOD      5'd31

// Control register bit positions
`define CS_CTRL_SYNCEN      0
`define CS_CTRL_MESEN       1
`define CS_CTRL_CH0EN       2
`define CS_CTRL_CH1EN       3
`define CS_CTRL_PRS_EN      4
`define CS_CTRL_SHIELD_INV  5

// Register reset values
`define CS_RST_CONTROL      8'h00
`define CS_RST_PRESCALE     8'd3
// Taps x^8 + x^6 + x^5 + x^4 + 1
`define CS_RST_POLY         8'hB8
`define CS_RST_SEED         8'hFF

`endif

// File: rtl/capsense_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types of the capsense clock generator
// Encodings are fixed, the testbench relies on them
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package capsense_pkg;

    // Measurement sequencer states
    typedef enum logic [1:0]
    {
        SEQ_IDLE          = 2'd0,
        // One cycle, clears the counters and loads the seed
        SEQ_PRECHARGE_RST = 2'd1,
        // Holds mesrst until mesen
        SEQ_MEASURE_RST   = 2'd2,
        SEQ_SCAN          = 2'd3
    } seq_state_t;

    // Configuration register addresses
    typedef enum logic [1:0]
    {
        CFG_CONTROL  = 2'd0,
        CFG_PRESCALE = 2'd1,
        CFG_POLY     = 2'd2,
        CFG_SEED     = 2'd3
    } cfg_addr_t;

endpackage

// File: rtl/capsense_cfg_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Timing registers are writable only while the sequencer is idle
// Control register is writable at any time
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "capsense_defines.svh"

module capsense_cfg_regs
(
    input  logic                          clk_TDM,
    input  logic                          reset1,
    // Register write port
    input  logic                          cfg_valid,
    input  capsense_pkg::cfg_addr_t       cfg_addr,
    input  logic [`CS_DATA_W-1:0]         cfg_wdata,
    output logic                          cfg_ready,
    // Sequencer state for the ready rule
    input  capsense_pkg::seq_state_t      seq_state,
    // Decoded control bits
    output logic                          syncen,
    output logic                          mesen,
    output logic                          ch0en,
    output logic                          ch1en,
    output logic                          prs_en,
    output logic                          shield_invert,
    // Timing values
    output logic [`CS_DATA_W-1:0]         prescale,
    output logic [`CS_DATA_W-1:0]         poly,
    output logic [`CS_DATA_W-1:0]         seed
);

    import capsense_pkg::*;

    logic [`CS_DATA_W-1:0] control_q;
    logic                  wr_fire;

    // Timing writes stall while a measurement runs
    assign cfg_ready = (cfg_addr == CFG_CONTROL) || (seq_state == SEQ_IDLE);
    assign wr_fire   = cfg_valid && cfg_ready;

    // Address decode, one register per write
    always_ff @(posedge clk_TDM or posedge reset1)
    begin
        if (reset1)
        begin
            control_q <= `CS_RST_CONTROL;
            prescale  <= `CS_RST_PRESCALE;
            poly      <= `CS_RST_POLY;
            seed      <= `CS_RST_SEED;
        end
        else if (wr_fire)
        begin
            case (cfg_addr)
                CFG_CONTROL:  control_q <= cfg_wdata;
                CFG_PRESCALE: prescale  <= cfg_wdata;
                CFG_POLY:     poly      <= cfg_wdata;
                CFG_SEED:     seed      <= cfg_wdata;
                default:      control_q <= control_q;
            endcase
        end
    end

    // Control bit fields
    assign syncen        = control_q[`CS_CTRL_SYNCEN];
    assign mesen         = control_q[`CS_CTRL_MESEN];
    assign ch0en         = control_q[`CS_CTRL_CH0EN];
    assign ch1en         = control_q[`CS_CTRL_CH1EN];
    assign prs_en        = control_q[`CS_CTRL_PRS_EN];
    assign shield_invert = control_q[`CS_CTRL_SHIELD_INV];

endmodule

// File: rtl/capsense_measure_seq.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// State and scan counter hold while enable is low
// Precharge reset lasts one enabled cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "capsense_defines.svh"

module capsense_measure_seq
(
    input  logic                     clk_TDM,
    input  logic                     reset1,
    input  logic                     enable,
    // Control bits
    input  logic                     syncen,
    input  logic                     mesen,
    input  logic                     ch0en,
    input  logic                     ch1en,
    // Sequencer status
    output capsense_pkg::seq_state_t seq_state,
    output logic                     cnt_clear,
    // Measurement outputs
    output logic                     mesrst,
    output logic                     start0,
    output logic                     start1,
    output logic                     dpulse
);

    import capsense_pkg::*;

    seq_state_t                state_q;
    seq_state_t                state_d;
    logic [`CS_SCAN_CNT_W-1:0] scan_cnt;

    // Next state
    always_comb
    begin
        state_d = state_q;
        case (state_q)
            SEQ_IDLE:          if (syncen)  state_d = SEQ_PRECHARGE_RST;
            SEQ_PRECHARGE_RST:              state_d = SEQ_MEASURE_RST;
            SEQ_MEASURE_RST:   if (mesen)   state_d = SEQ_SCAN;
            SEQ_SCAN:          if (!syncen) state_d = SEQ_IDLE;
            default:                        state_d = SEQ_IDLE;
        endcase
    end

    // State register
    always_ff @(posedge clk_TDM or posedge reset1)
    begin
        if (reset1)
        begin
            state_q <= SEQ_IDLE;
        end
        else if (enable)
        begin
            state_q <= state_d;
        end
    end

    // Scan-speed counter, reloads after zero
    always_ff @(posedge clk_TDM or posedge reset1)
    begin
        if (reset1)
        begin
            scan_cnt <= `CS_SCAN_PERIOD;
        end
        else if (enable)
        begin
            if (cnt_clear || (scan_cnt == '0))
                scan_cnt <= `CS_SCAN_PERIOD;
            else
                scan_cnt <= scan_cnt - 1'b1;
        end
    end

    assign seq_state = state_q;
    assign cnt_clear = (state_q == SEQ_PRECHARGE_RST);
    assign mesrst    = (state_q == SEQ_MEASURE_RST);
    // Channel starts follow the enables during scan
    assign start0    = (state_q == SEQ_SCAN) && ch0en;
    assign start1    = (state_q == SEQ_SCAN) && ch1en;
    // Digital clock, high for one cycle in 32
    assign dpulse    = (scan_cnt == '0);

endmodule

// File: rtl/capsense_prescaler.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tick period is prescale+1 enabled cycles
// A new prescale is taken at the next reload
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "capsense_defines.svh"

module capsense_prescaler
(
    input  logic                  clk_TDM,
    input  logic                  reset1,
    input  logic                  enable,
    // Load request from the precharge reset state
    input  logic                  cnt_clear,
    input  logic [`CS_DATA_W-1:0] prescale,
    // Precharge tick
    output logic                  pre_tick
);

    logic [`CS_DATA_W-1:0] pre_cnt;

    // Down-counter with reload
    always_ff @(posedge clk_TDM or posedge reset1)
    begin
        if (reset1)
        begin
            pre_cnt <= `CS_RST_PRESCALE;
        end
        else if (enable)
        begin
            // Restart on precharge or after the terminal count
            if (cnt_clear || (pre_cnt == '0))
            begin
                pre_cnt <= prescale;
            end
            else
            begin
                pre_cnt <= pre_cnt - 1'b1;
            end
        end
    end

    // High for one cycle at terminal count
    assign pre_tick = (pre_cnt == '0);

endmodule

// File: rtl/capsense_prs_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// A zero seed locks the PRS at zero
// Register and toggle step only on enabled ticks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "capsense_defines.svh"

module capsense_prs_gen
(
    input  logic                  clk_TDM,
    input  logic                  reset1,
    input  logic                  enable,
    // Seed load from the precharge reset state
    input  logic                  cnt_clear,
    input  logic                  pre_tick,
    // Configuration
    input  logic                  prs_en,
    input  logic                  shield_invert,
    input  logic [`CS_DATA_W-1:0] poly,
    input  logic [`CS_DATA_W-1:0] seed,
    // Precharge clock and shield drive
    output logic                  ppulse,
    output logic                  shield
);

    logic [`CS_DATA_W-1:0] prs_q;
    logic [`CS_DATA_W-1:0] prs_next;
    logic                  tgl_q;

    // Galois step, feedback from the old MSB
    assign prs_next = prs_q[`CS_DATA_W-1] ?
                      ({prs_q[`CS_DATA_W-2:0], 1'b0} ^ poly) :
                      {prs_q[`CS_DATA_W-2:0], 1'b0};

    always_ff @(posedge clk_TDM or posedge reset1)
    begin
        if (reset1)
        begin
            prs_q <= `CS_RST_SEED;
            tgl_q <= 1'b0;
        end
        else if (enable)
        begin
            if (cnt_clear)
            begin
                // Start every measurement from the seed, wave low
                prs_q <= seed;
                tgl_q <= 1'b0;
            end
            else if (pre_tick)
            begin
                prs_q <= prs_next;
                tgl_q <= ~tgl_q;
            end
        end
    end

    // Spread-spectrum bit or plain square wave
    assign ppulse = prs_en ? prs_q[`CS_DATA_W-1] : tgl_q;
    assign shield = ppulse ^ shield_invert;

endmodule

// File: rtl/capsense_clock_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Enable gates all counting state, not the register port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "capsense_defines.svh"

module capsense_clock_gen
(
    input  logic                    clk_TDM,
    input  logic                    reset1,
    input  logic                    enable,
    // Register write port
    input  logic                    cfg_valid,
    input  capsense_pkg::cfg_addr_t cfg_addr,
    input  logic [`CS_DATA_W-1:0]   cfg_wdata,
    output logic                    cfg_ready,
    // Sense clocks and measurement control
    output logic                    dpulse,
    output logic                    ppulse,
    output logic                    start0,
    output logic                    start1,
    output logic                    mesrst,
    output logic                    shield
);

    import capsense_pkg::*;

    // Control bits
    logic syncen;
    logic mesen;
    logic ch0en;
    logic ch1en;
    logic prs_en;
    logic shield_invert;
    // Timing values
    logic [`CS_DATA_W-1:0] prescale;
    logic [`CS_DATA_W-1:0] poly;
    logic [`CS_DATA_W-1:0] seed;
    // Sequencer to counters
    seq_state_t seq_state;
    logic       cnt_clear;
    logic       pre_tick;

    capsense_cfg_regs i_cfg_regs
    (
        .clk_TDM       (clk_TDM),
        .reset1        (reset1),
        .cfg_valid     (cfg_valid),
        .cfg_addr      (cfg_addr),
        .cfg_wdata     (cfg_wdata),
        .cfg_ready     (cfg_ready),
        .seq_state     (seq_state),
        .syncen        (syncen),
        .mesen         (mesen),
        .ch0en         (ch0en),
        .ch1en         (ch1en),
        .prs_en        (prs_en),
        .shield_invert (shield_invert),
        .prescale      (prescale),
        .poly          (poly),
        .seed          (seed)
    );

    capsense_measure_seq i_measure_seq
    (
        .clk_TDM   (clk_TDM),
        .reset1    (reset1),
        .enable    (enable),
        .syncen    (syncen),
        .mesen     (mesen),
        .ch0en     (ch0en),
        .ch1en     (ch1en),
        .seq_state (seq_state),
        .cnt_clear (cnt_clear),
        .mesrst    (mesrst),
        .start0    (start0),
        .start1    (start1),
        .dpulse    (dpulse)
    );

    // Precharge rate
    capsense_prescaler i_prescaler
    (
        .clk_TDM   (clk_TDM),
        .reset1    (reset1),
        .enable    (enable),
        .cnt_clear (cnt_clear),
        .prescale  (prescale),
        .pre_tick  (pre_tick)
    );

    capsense_prs_gen i_prs_gen
    (
        .clk_TDM       (clk_TDM),
        .reset1        (reset1),
        .enable        (enable),
        .cnt_clear     (cnt_clear),
        .pre_tick      (pre_tick),
        .prs_en        (prs_en),
        .shield_invert (shield_invert),
        .poly          (poly),
        .seed          (seed),
        .ppulse        (ppulse),
        .shield        (shield)
    );

endmodule

// File: verif/tb_capsense_clock_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Expects the register reset values of the register map
// Random timing values and enable gaps come from a fixed seed
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "capsense_defines.svh"

module tb_capsense_clock_gen;

    import capsense_pkg::*;

    localparam int WAIT_LIMIT = 300;

    logic                  clk_TDM;
    logic                  reset1;
    logic                  enable;
    logic                  cfg_valid;
    cfg_addr_t             cfg_addr;
    logic [`CS_DATA_W-1:0] cfg_wdata;
    logic                  cfg_ready;
    logic                  dpulse;
    logic                  ppulse;
    logic                  start0;
    logic                  start1;
    logic                  mesrst;
    logic                  shield;

    // Register contents as last written
    logic [`CS_DATA_W-1:0] sh_ctrl;
    logic [`CS_DATA_W-1:0] sh_prescale;
    logic [`CS_DATA_W-1:0] sh_poly;
    logic [`CS_DATA_W-1:0] sh_seed;
    // Reference model state
    logic                  model_on;
    logic                  tracking;
    logic                  en_last;
    logic                  mesrst_last;
    logic [`CS_DATA_W-1:0] ref_prs;
    logic                  ref_tgl;
    logic                  exp_pp;
    int                    ref_cnt;
    logic [31:0]           rng;
    logic [`CS_DATA_W-1:0] ctrl;
    int                    waits;
    int                    n;
    int                    round;

    capsense_clock_gen i_dut
    (
        .clk_TDM   (clk_TDM),
        .reset1    (reset1),
        .enable    (enable),
        .cfg_valid (cfg_valid),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_ready (cfg_ready),
        .dpulse    (dpulse),
        .ppulse    (ppulse),
        .start0    (start0),
        .start1    (start1),
        .mesrst    (mesrst),
        .shield    (shield)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // One Galois step with the taps applied when the old MSB was set
    function automatic logic [`CS_DATA_W-1:0] prs_step(input logic [`CS_DATA_W-1:0] cur,
                                                       input logic [`CS_DATA_W-1:0] taps);
        logic [`CS_DATA_W-1:0] shifted;
        shifted = {cur[`CS_DATA_W-2:0], 1'b0};
        return cur[`CS_DATA_W-1] ? (shifted ^ taps) : shifted;
    endfunction

    function automatic logic [`CS_DATA_W-1:0] control_word(input logic sync, input logic mes,
                                                           input logic ch0, input logic ch1,
                                                           input logic prs, input logic inv);
        logic [`CS_DATA_W-1:0] w;
        w = '0;
        w[`CS_CTRL_SYNCEN]     = sync;
        w[`CS_CTRL_MESEN]      = mes;
        w[`CS_CTRL_CH0EN]      = ch0;
        w[`CS_CTRL_CH1EN]      = ch1;
        w[`CS_CTRL_PRS_EN]     = prs;
        w[`CS_CTRL_SHIELD_INV] = inv;
        return w;
    endfunction

    task automatic stop_run(input string why);
        $display("TEST FAIL");
        $fatal(1, "%s", why);
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out after %0d cycles waiting for %s", WAIT_LIMIT, what);
        stop_run("wait limit reached");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_run("output bit differs from the expected value");
        end
    endtask

    task automatic check_state(input string name, input seq_state_t got, input seq_state_t exp);
        if (got !== exp)
        begin
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_run("sequencer state differs from the expected value");
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp)
        begin
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_run("count differs from the expected value");
        end
    endtask

    // Drive a request in the time step of a rising edge
    task automatic start_write(input cfg_addr_t addr, input logic [`CS_DATA_W-1:0] data);
        cfg_valid <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= data;
    endtask

    // Holds the request from a falling edge until ready
    task automatic finish_write(output int waited);
        waited = 0;
        while (!cfg_ready)
        begin
            waited = waited + 1;
            if (waited > WAIT_LIMIT)
                report_timeout("cfg_ready on a register write");
            @(negedge clk_TDM);
        end
        @(posedge clk_TDM);
        cfg_valid <= 1'b0;
        case (cfg_addr)
            CFG_CONTROL:  sh_ctrl     = cfg_wdata;
            CFG_PRESCALE: sh_prescale = cfg_wdata;
            CFG_POLY:     sh_poly     = cfg_wdata;
            default:      sh_seed     = cfg_wdata;
        endcase
    endtask

    task automatic write_reg(input cfg_addr_t addr, input logic [`CS_DATA_W-1:0] data,
                             output int waited);
        start_write(addr, data);
        @(negedge clk_TDM);
        finish_write(waited);
    endtask

    // Three enabled cycles in four on average
    task automatic random_enable(input int cycles);
        repeat (cycles)
        begin
            @(posedge clk_TDM);
            rng = xorshift32(rng);
            enable <= (rng[1:0] != 2'b00);
        end
    endtask

    initial
    begin
        clk_TDM = 1'b0;
        forever #5 clk_TDM = ~clk_TDM;
    end

    // Reference PRS and square wave compared at each falling edge
    always @(negedge clk_TDM)
    begin
        if (reset1 || !model_on)
        begin
            tracking = 1'b0;
        end
        else
        begin
            // Rising edge just passed counts only when enabled
            if (tracking && en_last)
            begin
                ref_cnt = ref_cnt + 1;
                if (ref_cnt == int'(sh_prescale) + 1)
                begin
                    ref_prs = prs_step(ref_prs, sh_poly);
                    ref_tgl = ~ref_tgl;
                    ref_cnt = 0;
                end
            end
            // Each measurement restarts from the seed with the wave low
            if (mesrst && !mesrst_last)
            begin
                tracking = 1'b1;
                ref_prs  = sh_seed;
                ref_tgl  = 1'b0;
                ref_cnt  = 0;
            end
            if (tracking)
            begin
                exp_pp = sh_ctrl[`CS_CTRL_PRS_EN] ? ref_prs[`CS_DATA_W-1] : ref_tgl;
                check_bit("ppulse", ppulse, exp_pp);
                check_bit("shield", shield, exp_pp ^ sh_ctrl[`CS_CTRL_SHIELD_INV]);
            end
        end
        mesrst_last = mesrst;
        en_last     = enable;
    end

    initial
    begin
        reset1      = 1'b1;
        enable      = 1'b0;
        cfg_valid   = 1'b0;
        cfg_addr    = CFG_PRESCALE;
        cfg_wdata   = '0;
        model_on    = 1'b0;
        rng         = 32'hca29eb53;
        sh_ctrl     = 8'h00;
        sh_prescale = 8'd3;
        sh_poly     = 8'hB8;
        sh_seed     = 8'hFF;
        repeat (5) @(posedge clk_TDM);
        reset1 <= 1'b0;

        // Quiet outputs after reset
        @(negedge clk_TDM);
        check_bit("mesrst", mesrst, 1'b0);
        check_bit("start0", start0, 1'b0);
        check_bit("start1", start1, 1'b0);
        check_bit("dpulse", dpulse, 1'b0);
        check_bit("ppulse", ppulse, 1'b0);
        check_bit("shield", shield, 1'b0);
        check_bit("cfg_ready", cfg_ready, 1'b1);
        check_state("seq_state", i_dut.seq_state, SEQ_IDLE);

        // Square wave at prescale 2 through precharge and measure reset
        @(posedge clk_TDM);
        enable <= 1'b1;
        write_reg(CFG_PRESCALE, 8'd2, waits);
        model_on = 1'b1;
        write_reg(CFG_CONTROL, control_word(1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0), waits);
        @(negedge clk_TDM);
        check_state("seq_state", i_dut.seq_state, SEQ_IDLE);
        @(negedge clk_TDM);
        check_state("seq_state", i_dut.seq_state, SEQ_PRECHARGE_RST);
        check_bit("mesrst", mesrst, 1'b0);
        // Two cycles after the write edge
        @(negedge clk_TDM);
        check_bit("mesrst", mesrst, 1'b1);
        repeat (20)
        begin
            @(negedge clk_TDM);
            check_bit("mesrst", mesrst, 1'b1);
        end
        @(posedge clk_TDM);
        write_reg(CFG_CONTROL, control_word(1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0), waits);
        @(negedge clk_TDM);
        check_bit("mesrst", mesrst, 1'b1);
        @(negedge clk_TDM);
        check_bit("mesrst", mesrst, 1'b0);
        check_bit("start0", start0, 1'b1);
        check_bit("start1", start1, 1'b0);
        // Channel 1 on and shield inverted while scanning
        @(posedge clk_TDM);
        write_reg(CFG_CONTROL, control_word(1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1), waits);
        check_count("control write wait cycles", waits, 0);
        @(negedge clk_TDM);
        check_bit("start1", start1, 1'b1);

        // dpulse spacing in scan
        n = 0;
        while (!dpulse)
        begin
            n = n + 1;
            if (n > WAIT_LIMIT)
                report_timeout("the first dpulse in the scan state");
            @(negedge clk_TDM);
        end
        repeat (2)
        begin
            @(negedge clk_TDM);
            n = 1;
            while (!dpulse)
            begin
                if (n > WAIT_LIMIT)
                    report_timeout("the next dpulse");
                @(negedge clk_TDM);
                n = n + 1;
            end
            check_count("dpulse interval", n, 32);
        end

        // Leaving scan stalls the prescale write behind it until idle
        @(posedge clk_TDM);
        model_on = 1'b0;
        write_reg(CFG_CONTROL, control_word(1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0), waits);
        check_count("control write wait cycles", waits, 0);
        start_write(CFG_PRESCALE, 8'd5);
        @(negedge clk_TDM);
        check_bit("cfg_ready", cfg_ready, 1'b0);
        check_bit("start0", start0, 1'b1);
        check_bit("start1", start1, 1'b1);
        @(negedge clk_TDM);
        check_bit("cfg_ready", cfg_ready, 1'b1);
        check_bit("start0", start0, 1'b0);
        check_bit("start1", start1, 1'b0);
        finish_write(waits);
        @(negedge clk_TDM);
        check_count("prescale register", int'(i_dut.prescale), 5);

        // Random PRS runs with enable gaps
        for (round = 0; round < 4; round++)
        begin
            @(posedge clk_TDM);
            rng = xorshift32(rng);
            write_reg(CFG_PRESCALE, {5'd0, rng[2:0]}, waits);
            rng = xorshift32(rng);
            write_reg(CFG_POLY, rng[7:0], waits);
            rng = xorshift32(rng);
            // Zero seed would lock the PRS
            write_reg(CFG_SEED, (rng[7:0] == 8'h00) ? 8'h5A : rng[7:0], waits);
            model_on = 1'b1;
            rng = xorshift32(rng);
            ctrl = control_word(1'b1, 1'b0, 1'b1, 1'b0, 1'b1, rng[0]);
            write_reg(CFG_CONTROL, ctrl, waits);
            random_enable(40);
            enable <= 1'b1;
            n = 0;
            @(negedge clk_TDM);
            while (!mesrst)
            begin
                n = n + 1;
                if (n > WAIT_LIMIT)
                    report_timeout("mesrst in a PRS run");
                @(negedge clk_TDM);
            end
            @(posedge clk_TDM);
            write_reg(CFG_CONTROL, ctrl | control_word(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0), waits);
            random_enable(150);
            enable <= 1'b1;
            model_on = 1'b0;
            write_reg(CFG_CONTROL, 8'h00, waits);
            n = 0;
            @(negedge clk_TDM);
            while (i_dut.seq_state != SEQ_IDLE)
            begin
                n = n + 1;
                if (n > WAIT_LIMIT)
                    report_timeout("the sequencer to return to idle");
                @(negedge clk_TDM);
            end
        end

        @(negedge clk_TDM);
        $display("TEST PASS");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+rtl
rtl/capsense_pkg.sv
rtl/capsense_cfg_regs.sv
rtl/capsense_measure_seq.sv
rtl/capsense_prescaler.sv
rtl/capsense_prs_gen.sv
rtl/capsense_clock_gen.sv
verif/tb_capsense_clock_gen.sv
